// File: synth_top.f
hw/synth_pkg.sv
hw/synth_if.sv
hw/synth_apb_regs.sv
hw/synth_clk_gen.sv
hw/voice_mixer.sv
hw/i2s_serializer.sv
hw/synth_top.sv
tests/synth_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the synth testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module synth_tb \
    -f synth_top.f \
    -o synth_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/synth_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

// File: tests/synth_tb.sv
`timescale 1ns/1ps
`default_nettype none

module synth_tb import synth_pkg::*; ();

    logic              AUDIO_CLK;
    logic              reset_reg_N;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic              aud_daclrck;
    logic              aud_bclk;
    logic              aud_dacdat;

    // Model's copy of the staging registers as written over APB
    logic [PHASE_WIDTH-1:0] sh_inc  [VOICES];
    logic [GAIN_WIDTH-1:0]  sh_gl   [VOICES];
    logic [GAIN_WIDTH-1:0]  sh_gr   [VOICES];
    logic                   sh_en   [VOICES];
    logic                   sh_run;
    logic [PHASE_WIDTH-1:0] m_phase [VOICES];   // Model saw phases
    sample_t                exp_l_q [$];        // One entry per frame on the wire
    sample_t                exp_r_q [$];
    logic [31:0]            lfsr;
    logic                   running;            // Out of reset
    int                     cycle_cnt;
    logic [31:0]            cap_sh;             // Serial bits with the newest in bit 0
    logic                   cap_lrck_q;
    logic                   mon_lrck_q;
    logic                   mon_bclk_q;
    int                     mon_gap;
    int                     mon_rises;
    int                     mon_toggles;
    int                     mon_falls;

    synth_top synth_top_inst (.*);              // Port names match one to one

    initial
    begin
        AUDIO_CLK = 1'b0;
        forever #20 AUDIO_CLK = ~AUDIO_CLK;     // 40 ns period
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic check_sample(input string name, input sample_t exp, input sample_t act);
        if (exp !== act)
        begin
            $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            $display("Something failed");
            $fatal(1, "sample mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [APB_DW-1:0] exp,
                              input logic [APB_DW-1:0] act);
        if (exp !== act)
        begin
            $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            $display("Something failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            $display("Something failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Random source and reference mixer
    ////////////////////////////////////////
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
            val = {val[30:0], lfsr_step()};
        return val;
    endfunction

    // One frame of the mix from the registers as they stand at the LRCK fall
    function automatic void ref_mix(output sample_t l, output sample_t r);
        int acc_l;
        int acc_r;
        int saw;
        int scaled_l;
        int scaled_r;
        acc_l = 0;
        acc_r = 0;
        for (int v = 0; v < VOICES; v++)
        begin
            if (sh_run && sh_en[v])                  // Otherwise silent and phase holds
            begin
                saw        = int'($signed(m_phase[v][PHASE_WIDTH-1 -: 8]));
                acc_l      = acc_l + saw * int'(sh_gl[v]);
                acc_r      = acc_r + saw * int'(sh_gr[v]);
                m_phase[v] = m_phase[v] + sh_inc[v];   // 16-bit wrap
            end
        end
        scaled_l = acc_l >>> 2;
        scaled_r = acc_r >>> 2;
        l = scaled_l[DATA_WIDTH-1:0];
        r = scaled_r[DATA_WIDTH-1:0];
    endfunction

    ////////////////////////////////////////
    // APB access
    ////////////////////////////////////////
    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             input logic exp_err);
        @(negedge AUDIO_CLK);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge AUDIO_CLK);
        penable = 1'b1;
        @(negedge AUDIO_CLK);                   // Still in access phase here
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] exp,
                            input logic exp_err);
        @(negedge AUDIO_CLK);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge AUDIO_CLK);
        penable = 1'b1;
        @(negedge AUDIO_CLK);
        check_bit("pready", 1'b1, pready);
        check_bit("pslverr", exp_err, pslverr);
        check_word("prdata", exp, prdata);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_inc(input int v, input logic [PHASE_WIDTH-1:0] inc);
        apb_write(APB_AW'(v * 16 + REG_INC), {16'h0, inc}, 1'b0);
        sh_inc[v] = inc;
    endtask

    task automatic set_gain(input int v, input logic [GAIN_WIDTH-1:0] gl,
                            input logic [GAIN_WIDTH-1:0] gr);
        apb_write(APB_AW'(v * 16 + REG_GAIN), {16'h0, gr, gl}, 1'b0);
        sh_gl[v] = gl;
        sh_gr[v] = gr;
    endtask

    task automatic set_en(input int v, input logic en);
        apb_write(APB_AW'(v * 16 + REG_CTRL), {31'h0, en}, 1'b0);
        sh_en[v] = en;
    endtask

    task automatic set_run(input logic run);
        apb_write(GLOBAL_CTRL_ADDR, {31'h0, run}, 1'b0);
        sh_run = run;
    endtask

    task automatic random_voice(input int v, input logic en);
        logic [GAIN_WIDTH-1:0] gl;
        logic [GAIN_WIDTH-1:0] gr;
        set_inc(v, PHASE_WIDTH'(rand_bits(PHASE_WIDTH)));
        gl = GAIN_WIDTH'(rand_bits(GAIN_WIDTH));
        gr = GAIN_WIDTH'(rand_bits(GAIN_WIDTH));
        set_gain(v, gl, gr);
        set_en(v, en);
    endtask

    task automatic read_all();
        for (int v = 0; v < VOICES; v++)
        begin
            apb_read(APB_AW'(v * 16 + REG_INC), {16'h0, sh_inc[v]}, 1'b0);
            apb_read(APB_AW'(v * 16 + REG_GAIN), {16'h0, sh_gr[v], sh_gl[v]}, 1'b0);
            apb_read(APB_AW'(v * 16 + REG_CTRL), {31'h0, sh_en[v]}, 1'b0);
        end
        apb_read(GLOBAL_CTRL_ADDR, {31'h0, sh_run}, 1'b0);
    endtask

    task automatic wait_frames(input int n);
        repeat (n) @(negedge aud_daclrck);      // Writes after this land in the next frame
    endtask

    ////////////////////////////////////////
    // Monitors
    ////////////////////////////////////////
    always @(negedge aud_daclrck)
    begin : frame_model
        sample_t l;
        sample_t r;
        if (running)
        begin
            ref_mix(l, r);
            exp_l_q.push_back(l);               // On the wire one frame later
            exp_r_q.push_back(r);
        end
    end

    always @(posedge aud_bclk)
    begin : i2s_capture
        sample_t el;
        sample_t er;
        if (running)
        begin
            cap_sh = {cap_sh[30:0], aud_dacdat};
            if (cap_lrck_q && !aud_daclrck)     // Slot 0 where the right LSB was just taken
            begin
                if (exp_l_q.size() == 0)
                begin
                    $display("A frame arrived on the I2S output with nothing expected");
                    $display("Something failed");
                    $fatal(1, "expected queue empty");
                end
                else
                begin
                    el = exp_l_q.pop_front();
                    er = exp_r_q.pop_front();
                    check_sample("left sample", el, sample_t'(cap_sh[31:16]));
                    check_sample("right sample", er, sample_t'(cap_sh[15:0]));
                end
            end
            cap_lrck_q = aud_daclrck;
        end
    end

    // LRCK and BCLK relation sampled mid-cycle
    always @(negedge AUDIO_CLK)
    begin
        if (running)
        begin
            mon_gap++;
            if (aud_bclk && !mon_bclk_q)
                mon_rises++;
            if (aud_daclrck != mon_lrck_q)
            begin
                check_bit("aud_bclk fall at aud_daclrck edge", 1'b1, mon_bclk_q && !aud_bclk);
                if (mon_toggles > 0)
                    check_word("cycles per aud_daclrck level", LRCK_DIV, mon_gap);
                if (!aud_daclrck && mon_falls > 0)
                    check_word("aud_bclk rises per aud_daclrck period",
                               FRAME_CYCLES / (2 * BCK_DIV), mon_rises);
                if (!aud_daclrck)
                begin
                    mon_falls++;
                    mon_rises = 0;
                end
                mon_toggles++;
                mon_gap = 0;
            end
            mon_lrck_q = aud_daclrck;
            mon_bclk_q = aud_bclk;
        end
    end

    always @(posedge AUDIO_CLK)
    begin
        cycle_cnt++;
        if (cycle_cnt >= 24000)                 // About 40 frames of 256 with 2.3x margin
        begin
            $display("Run did not finish within %0d clock cycles", cycle_cnt);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    ////////////////////////////////////////
    // Scenarios
    ////////////////////////////////////////
    initial
    begin
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        reset_reg_N = 1'b1;                     // Dropped below so the reset edge is seen
        running     = 1'b0;
        lfsr        = 32'ha1a3_a4fb;
        cycle_cnt   = 0;
        cap_sh      = '0;
        cap_lrck_q  = 1'b0;
        mon_lrck_q  = 1'b0;
        mon_bclk_q  = 1'b0;
        mon_gap     = 0;
        mon_rises   = 0;
        mon_toggles = 0;
        mon_falls   = 0;
        sh_run      = 1'b0;
        for (int v = 0; v < VOICES; v++)
        begin
            sh_inc[v]  = '0;
            sh_gl[v]   = '0;
            sh_gr[v]   = '0;
            sh_en[v]   = 1'b0;
            m_phase[v] = '0;
        end
        // Partial frame before the first LRCK fall and then the silent first frame
        repeat (2)
        begin
            exp_l_q.push_back('0);
            exp_r_q.push_back('0);
        end

        @(negedge AUDIO_CLK);
        reset_reg_N = 1'b0;
        @(negedge AUDIO_CLK);
        check_bit("aud_daclrck in reset", 1'b0, aud_daclrck);
        check_bit("aud_bclk in reset", 1'b0, aud_bclk);
        check_bit("aud_dacdat in reset", 1'b0, aud_dacdat);
        check_bit("pready in reset", 1'b0, pready);
        @(negedge AUDIO_CLK);
        reset_reg_N = 1'b1;
        running     = 1'b1;
        @(negedge AUDIO_CLK);
        check_bit("aud_daclrck after reset", 1'b0, aud_daclrck);
        check_bit("aud_bclk after reset", 1'b0, aud_bclk);
        check_bit("aud_dacdat after reset", 1'b0, aud_dacdat);
        check_bit("pready after reset", 1'b0, pready);
        read_all();                             // All zero out of reset

        // Register readback and unmapped addresses
        for (int v = 0; v < VOICES; v++)
            random_voice(v, lfsr_step());
        set_run(1'b0);
        read_all();
        apb_write(8'h0C, 32'hFFFF_FFFF, 1'b1);
        apb_write(8'h80, 32'hFFFF_FFFF, 1'b1);
        apb_read(8'h0C, 32'h0, 1'b1);
        apb_read(8'h44, 32'h0, 1'b1);
        apb_read(8'hC4, 32'h0, 1'b1);
        read_all();                             // Unmapped writes left nothing behind

        // Voices configured but run still low
        for (int v = 0; v < VOICES; v++)
            set_en(v, 1'b1);
        wait_frames(3);

        // Voice 0 alone with run starting here
        wait_frames(1);
        for (int v = 1; v < VOICES; v++)
            set_en(v, 1'b0);
        random_voice(0, 1'b1);
        set_run(1'b1);
        wait_frames(10);

        // All voices and then changes between frames
        for (int v = 0; v < VOICES; v++)
            random_voice(v, 1'b1);
        wait_frames(4);
        set_en(2, 1'b0);                        // Voice 2 phase should hold from here
        set_inc(1, PHASE_WIDTH'(rand_bits(PHASE_WIDTH)));
        wait_frames(4);
        set_en(2, 1'b1);
        set_inc(3, PHASE_WIDTH'(rand_bits(PHASE_WIDTH)));
        wait_frames(6);                         // Two extra frames drain the I2S pipeline

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/synth_top.sv
`timescale 1ns/1ps
`default_nettype none

module synth_top import synth_pkg::*; (
    input  wire logic              AUDIO_CLK,
    input  wire logic              reset_reg_N,
    // APB3 configuration port
    input  wire logic [APB_AW-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [APB_DW-1:0] pwdata,
    output logic      [APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    // I2S DAC
    output logic                   aud_daclrck,
    output logic                   aud_bclk,
    output logic                   aud_dacdat
);

    logic frame_start;     // LRCK fall
    logic bclk_fall;

    voice_cfg_if cfg_if ();
    sample_if    smp_if ();

    ////////////////////////////////////////
    // Timing and configuration
    ////////////////////////////////////////
    synth_clk_gen synth_clk_gen_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .aud_daclrck (aud_daclrck),
        .aud_bclk    (aud_bclk),
        .frame_start (frame_start),
        .bclk_fall   (bclk_fall)
    );

    synth_apb_regs synth_apb_regs_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .frame_start (frame_start),
        .cfg         (cfg_if.provider)
    );

    ////////////////////////////////////////
    // Sample path
    ////////////////////////////////////////
    voice_mixer voice_mixer_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .frame_start (frame_start),
        .cfg         (cfg_if.consumer),
        .smp         (smp_if.source)
    );

    i2s_serializer i2s_serializer_inst (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .frame_start (frame_start),
        .bclk_fall   (bclk_fall),
        .lrck        (aud_daclrck),   // Serializer tracks the channel edges
        .smp         (smp_if.sink),
        .aud_dacdat  (aud_dacdat)
    );

endmodule

`default_nettype wire

// File: hw/i2s_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer import synth_pkg::*; (
    input  wire logic AUDIO_CLK,
    input  wire logic reset_reg_N,
    input  wire logic frame_start,
    input  wire logic bclk_fall,
    input  wire logic lrck,
    sample_if.sink    smp,
    output logic      aud_dacdat
);

    sample_t               held_l;     // Last complete pair from the mixer
    sample_t               held_r;
    sample_t               out_r;      // Right word of the frame on the wire
    logic [DATA_WIDTH-1:0] shreg;      // Word being shifted out
    logic                  lrck_q;
    logic                  lrck_rise;

    assign lrck_rise = lrck && !lrck_q;

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            held_l     <= '0;          // First frame after reset goes out silent
            held_r     <= '0;
            out_r      <= '0;
            shreg      <= '0;
            lrck_q     <= 1'b0;
            aud_dacdat <= 1'b0;
        end
        else
        begin
            lrck_q <= lrck;

            if (smp.valid)
            begin
                held_l <= smp.left;
                held_r <= smp.right;
            end

            // Snapshot before the mixer replaces the held pair
            if (smp.frame)
                out_r <= held_r;

            ////////////////////////////////////////
            // Bit slots, MSB first
            ////////////////////////////////////////
            if (bclk_fall)
            begin
                aud_dacdat <= shreg[DATA_WIDTH-1];   // Previous LSB in the edge slot
                if (frame_start)
                    shreg <= held_l;                 // Left MSB one slot later
                else if (lrck_rise)
                    shreg <= out_r;                  // Right MSB one slot later
                else
                    shreg <= {shreg[DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/voice_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module voice_mixer import synth_pkg::*; (
    input  wire logic     AUDIO_CLK,
    input  wire logic     reset_reg_N,
    input  wire logic     frame_start,
    voice_cfg_if.consumer cfg,
    sample_if.source      smp
);

    mix_state_t                   state;
    logic [VOICE_W-1:0]           vidx;                 // Voice in the accumulate step
    logic [PHASE_WIDTH-1:0]       phase [VOICES];       // One saw phase per voice
    logic signed [SAW_WIDTH-1:0]  saw;
    logic signed [PROD_WIDTH-1:0] prod_l;
    logic signed [PROD_WIDTH-1:0] prod_r;
    logic signed [ACC_WIDTH-1:0]  acc_l;
    logic signed [ACC_WIDTH-1:0]  acc_r;
    logic signed [ACC_WIDTH-1:0]  mix_l;
    logic signed [ACC_WIDTH-1:0]  mix_r;
    logic                         active;
    logic                         last_voice;

    assign cfg.voice_sel = vidx;

    ////////////////////////////////////////
    // Per-voice contribution
    ////////////////////////////////////////
    assign saw        = phase[vidx][PHASE_WIDTH-1 -: SAW_WIDTH];   // Signed ramp
    assign active     = cfg.enable && cfg.run;
    assign last_voice = (vidx == VOICE_W'(VOICES - 1));

    // Gain zero-extended so the product stays signed
    assign prod_l = saw * $signed({1'b0, cfg.gain_l});
    assign prod_r = saw * $signed({1'b0, cfg.gain_r});

    assign mix_l = acc_l >>> MIX_SHIFT;    // Arithmetic scale down
    assign mix_r = acc_r >>> MIX_SHIFT;

    ////////////////////////////////////////
    // Frame sequencer
    ////////////////////////////////////////
    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            state <= MIX_IDLE;
            vidx  <= '0;
            acc_l <= '0;
            acc_r <= '0;
            for (int v = 0; v < VOICES; v++)
            begin
                phase[v] <= '0;
            end
            smp.left  <= '0;
            smp.right <= '0;
            smp.valid <= 1'b0;
            smp.frame <= 1'b0;
        end
        else
        begin
            smp.valid <= 1'b0;
            smp.frame <= frame_start;      // Marks the start of a new mix
            case (state)
                MIX_IDLE:
                begin
                    if (frame_start)       // Active set is valid from next cycle
                    begin
                        state <= MIX_ACCUM;
                        vidx  <= '0;
                        acc_l <= '0;
                        acc_r <= '0;
                    end
                end
                MIX_ACCUM:
                begin
                    if (active)            // Disabled or stopped voice holds its phase
                    begin
                        acc_l       <= acc_l + prod_l;
                        acc_r       <= acc_r + prod_r;
                        phase[vidx] <= phase[vidx] + cfg.inc;   // Wraps
                    end
                    if (last_voice)
                        state <= MIX_OUT;
                    else
                        vidx <= vidx + 1'b1;
                end
                MIX_OUT:
                begin
                    smp.left  <= sample_t'(mix_l[DATA_WIDTH-1:0]);
                    smp.right <= sample_t'(mix_r[DATA_WIDTH-1:0]);
                    smp.valid <= 1'b1;
                    state     <= MIX_IDLE;
                end
                default: state <= MIX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/synth_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module synth_clk_gen import synth_pkg::*; (
    input  wire logic AUDIO_CLK,
    input  wire logic reset_reg_N,
    output logic      aud_daclrck,    // Low for left, high for right
    output logic      aud_bclk,
    output logic      frame_start,    // Cycle of the LRCK fall
    output logic      bclk_fall       // Cycle of each BCLK fall
);

    logic [LRCK_WIDTH-1:0] lrck_cnt;
    logic [BCK_WIDTH-1:0]  bck_cnt;
    logic                  lrck_wrap;
    logic                  bck_wrap;

    // Last count before a toggle
    assign lrck_wrap = (lrck_cnt == LRCK_WIDTH'(LRCK_DIV - 1));
    assign bck_wrap  = (bck_cnt == BCK_WIDTH'(BCK_DIV - 1));

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            lrck_cnt    <= '0;
            aud_daclrck <= 1'b0;
            bck_cnt     <= '0;
            aud_bclk    <= 1'b0;
            frame_start <= 1'b0;
            bclk_fall   <= 1'b0;
        end
        else
        begin
            ////////////////////////////////////////
            // LRCK divider
            ////////////////////////////////////////
            if (lrck_wrap)
            begin
                lrck_cnt    <= '0;
                aud_daclrck <= ~aud_daclrck;
            end
            else
                lrck_cnt <= lrck_cnt + 1'b1;

            ////////////////////////////////////////
            // BCLK divider
            ////////////////////////////////////////
            if (bck_wrap)
            begin
                bck_cnt  <= '0;
                aud_bclk <= ~aud_bclk;
            end
            else
                bck_cnt <= bck_cnt + 1'b1;

            // Strobes line up with the clock edges they mark
            frame_start <= lrck_wrap && aud_daclrck;   // High to low is left channel start
            bclk_fall   <= bck_wrap && aud_bclk;
        end
    end

endmodule

`default_nettype wire

// File: hw/synth_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module synth_apb_regs import synth_pkg::*; (
    input  wire logic              AUDIO_CLK,
    input  wire logic              reset_reg_N,
    input  wire logic [APB_AW-1:0] paddr,
    input  wire logic              psel,
    input  wire logic              penable,
    input  wire logic              pwrite,
    input  wire logic [APB_DW-1:0] pwdata,
    output logic      [APB_DW-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  wire logic              frame_start,
    voice_cfg_if.provider          cfg
);

    // Staging set, written by APB and read back
    logic [PHASE_WIDTH-1:0] stg_inc    [VOICES];
    logic [GAIN_WIDTH-1:0]  stg_gain_l [VOICES];
    logic [GAIN_WIDTH-1:0]  stg_gain_r [VOICES];
    logic [VOICES-1:0]      stg_en;
    logic                   stg_run;
    // Active set, seen by the mixer for a whole frame
    logic [PHASE_WIDTH-1:0] act_inc    [VOICES];
    logic [GAIN_WIDTH-1:0]  act_gain_l [VOICES];
    logic [GAIN_WIDTH-1:0]  act_gain_r [VOICES];
    logic [VOICES-1:0]      act_en;
    logic                   act_run;

    logic [VOICE_W-1:0] vidx;
    reg_off_t           off;
    logic               is_voice;
    logic               is_global;
    logic               off_ok;
    logic               mapped;
    logic               access;
    logic [APB_DW-1:0]  rdata;

    ////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////
    assign vidx      = paddr[OFF_W +: VOICE_W];
    assign off       = reg_off_t'(paddr[OFF_W-1:0]);
    assign is_voice  = (paddr[APB_AW-1:OFF_W+VOICE_W] == '0);
    assign is_global = (paddr == GLOBAL_CTRL_ADDR);
    assign off_ok    = (off == REG_INC) || (off == REG_GAIN) || (off == REG_CTRL);
    assign mapped    = (is_voice && off_ok) || is_global;
    assign access    = psel && penable;           // APB access phase

    assign pready  = access;                      // Zero wait states
    assign pslverr = access && !mapped;

    always_comb
    begin
        rdata = '0;                               // Unmapped reads as zero
        if (is_global)
            rdata[0] = stg_run;
        else if (is_voice)
        begin
            case (off)
                REG_INC:  rdata[PHASE_WIDTH-1:0] = stg_inc[vidx];
                REG_GAIN:
                begin
                    rdata[GAIN_WIDTH-1:0]            = stg_gain_l[vidx];
                    rdata[2*GAIN_WIDTH-1:GAIN_WIDTH] = stg_gain_r[vidx];
                end
                REG_CTRL: rdata[0] = stg_en[vidx];
                default:  rdata = '0;
            endcase
        end
    end

    assign prdata = (psel && !pwrite) ? rdata : '0;

    ////////////////////////////////////////
    // Staging writes and frame copy
    ////////////////////////////////////////
    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N)
    begin
        if (!reset_reg_N)
        begin
            for (int v = 0; v < VOICES; v++)
            begin
                stg_inc[v]    <= '0;
                stg_gain_l[v] <= '0;
                stg_gain_r[v] <= '0;
                act_inc[v]    <= '0;
                act_gain_l[v] <= '0;
                act_gain_r[v] <= '0;
            end
            stg_en         <= '0;
            stg_run        <= 1'b0;
            act_en         <= '0;
            act_run        <= 1'b0;
            cfg.frame_load <= 1'b0;
        end
        else
        begin
            if (access && pwrite && mapped)
            begin
                if (is_global)
                    stg_run <= pwdata[0];
                else if (off == REG_INC)
                    stg_inc[vidx] <= pwdata[PHASE_WIDTH-1:0];
                else if (off == REG_GAIN)
                begin
                    stg_gain_l[vidx] <= pwdata[GAIN_WIDTH-1:0];
                    stg_gain_r[vidx] <= pwdata[2*GAIN_WIDTH-1:GAIN_WIDTH];
                end
                else
                    stg_en[vidx] <= pwdata[0];
            end
            if (frame_start)                      // Settings only change between frames
            begin
                act_inc    <= stg_inc;
                act_gain_l <= stg_gain_l;
                act_gain_r <= stg_gain_r;
                act_en     <= stg_en;
                act_run    <= stg_run;
            end
            cfg.frame_load <= frame_start;        // High once the copy has landed
        end
    end

    // Lookup for the voice the mixer is on
    assign cfg.inc    = act_inc[cfg.voice_sel];
    assign cfg.gain_l = act_gain_l[cfg.voice_sel];
    assign cfg.gain_r = act_gain_r[cfg.voice_sel];
    assign cfg.enable = act_en[cfg.voice_sel];
    assign cfg.run    = act_run;

endmodule

`default_nettype wire

// File: hw/synth_if.sv
`timescale 1ns/1ps
`default_nettype none

// Active voice settings, looked up by the mixer one voice at a time
interface voice_cfg_if import synth_pkg::*; ();
    logic [VOICE_W-1:0]     voice_sel;     // Voice being mixed
    logic [PHASE_WIDTH-1:0] inc;
    logic [GAIN_WIDTH-1:0]  gain_l;
    logic [GAIN_WIDTH-1:0]  gain_r;
    logic                   enable;
    logic                   run;           // Global run bit
    logic                   frame_load;    // Active set was just refreshed

    modport provider (
        input  voice_sel,
        output inc,
        output gain_l,
        output gain_r,
        output enable,
        output run,
        output frame_load
    );

    modport consumer (
        output voice_sel,
        input  inc,
        input  gain_l,
        input  gain_r,
        input  enable,
        input  run,
        input  frame_load
    );
endinterface

// Mixed stereo pair from mixer to serializer
interface sample_if import synth_pkg::*; ();
    sample_t left;
    sample_t right;
    logic    valid;                        // One cycle, both words final
    logic    frame;                        // Mix of a new frame has begun

    modport source (output left, output right, output valid, output frame);
    modport sink   (input left, input right, input valid, input frame);
endinterface

`default_nettype wire

// File: hw/synth_pkg.sv
`default_nettype none

package synth_pkg;

    ////////////////////////////////////////
    // Voice and sample widths
    ////////////////////////////////////////
    localparam int VOICES      = 4;
    localparam int VOICE_W     = $clog2(VOICES);
    localparam int DATA_WIDTH  = 16;                 // DAC sample width
    localparam int PHASE_WIDTH = 16;                 // Phase accumulator and increment
    localparam int GAIN_WIDTH  = 8;                  // Unsigned per-channel gain
    localparam int SAW_WIDTH   = 8;                  // Top phase bits used as saw value
    localparam int PROD_WIDTH  = SAW_WIDTH + GAIN_WIDTH + 1;
    localparam int ACC_WIDTH   = 18;                 // Four products plus headroom
    localparam int MIX_SHIFT   = 2;                  // Scale back into sample range

    ////////////////////////////////////////
    // Frame timing
    ////////////////////////////////////////
    localparam int FRAME_CYCLES = 256;               // AUDIO_CLK cycles per stereo frame
    localparam int LRCK_DIV     = FRAME_CYCLES / 2;  // Half frame per LRCK level
    localparam int BCK_DIV      = 4;                 // 32 bit slots per frame
    localparam int LRCK_WIDTH   = $clog2(LRCK_DIV);
    localparam int BCK_WIDTH    = $clog2(BCK_DIV);

    ////////////////////////////////////////
    // APB register map
    ////////////////////////////////////////
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;
    localparam int OFF_W  = 4;                       // Per-voice window of 16 bytes
    localparam logic [APB_AW-1:0] GLOBAL_CTRL_ADDR = 8'h40;   // Bit 0 is run

    typedef enum logic [OFF_W-1:0] {
        REG_INC  = 4'h0,    // Phase increment
        REG_GAIN = 4'h4,    // Left gain 7:0, right gain 15:8
        REG_CTRL = 4'h8     // Voice enable
    } reg_off_t;

    typedef enum logic [1:0] {MIX_IDLE, MIX_ACCUM, MIX_OUT} mix_state_t;

    typedef logic signed [DATA_WIDTH-1:0] sample_t;

endpackage

`default_nettype wire
